// ==== logic/l2_pkg.sv ====
`default_nettype none

package l2_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ADDR_BITS   = 16;
    localparam int L2_SET_BITS = 4;
    localparam int L2_SETS     = 1 << L2_SET_BITS;
    localparam int L2_TAG_BITS = ADDR_BITS - L2_SET_BITS;
    localparam int LINE_BITS   = 32;
    localparam int HPROT_BITS  = 2;

    typedef logic [ADDR_BITS-1:0]   addr_t;
    typedef logic [L2_TAG_BITS-1:0] l2_tag_t;
    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [HPROT_BITS-1:0]  hprot_t;

    // VALID is kept for a later fill path.
    typedef enum logic [1:0] {
        INVALID = 2'd0,
        VALID   = 2'd1,
        DIRTY   = 2'd2
    } state_t;

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_INVAL = 2'd2
    } l2_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request and response.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        l2_op_t  op;
        addr_t   addr;
        line_t   wr_line;
        hprot_t  wr_hprot;
    } l2_req_t;

    typedef struct packed {
        logic    hit;
        line_t   rd_line;
        hprot_t  rd_hprot;
        state_t  state;
        logic    evicted;
        l2_tag_t evict_tag;
        logic    evict_dirty;
    } l2_rsp_t;

    // set index is the low address bits, tag the rest.
    function automatic logic [L2_SET_BITS-1:0] set_of(addr_t addr);
        return addr[L2_SET_BITS-1:0];
    endfunction

    function automatic l2_tag_t tag_of(addr_t addr);
        return addr[ADDR_BITS-1:L2_SET_BITS];
    endfunction

endpackage

`default_nettype wire

// ==== logic/l2_set_array.sv ====
`default_nettype none

module l2_set_array
    import l2_pkg::*;
#(
    parameter  int WAYS     = 4,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [L2_SET_BITS-1:0] set_idx,
    input  logic                   rd_set,
    input  logic                   wr_set,
    input  line_t                  wr_line [WAYS],
    input  l2_tag_t                wr_tag [WAYS],
    input  hprot_t                 wr_hprot [WAYS],
    input  state_t                 wr_state [WAYS],
    input  logic [WAY_BITS-1:0]    wr_evict_way,
    output line_t                  rd_data_line [WAYS],
    output l2_tag_t                rd_data_tag [WAYS],
    output hprot_t                 rd_data_hprot [WAYS],
    output state_t                 rd_data_state [WAYS],
    output logic [WAY_BITS-1:0]    rd_data_evict_way
);

    line_t               line_mem  [L2_SETS][WAYS];
    l2_tag_t             tag_mem   [L2_SETS][WAYS];
    hprot_t              hprot_mem [L2_SETS][WAYS];
    state_t              state_mem [L2_SETS][WAYS];
    logic [WAY_BITS-1:0] evict_mem [L2_SETS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // whole-set write.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (wr_set) begin
            for (int w = 0; w < WAYS; w++) begin
                line_mem[set_idx][w]  <= wr_line[w];
                tag_mem[set_idx][w]   <= wr_tag[w];
                hprot_mem[set_idx][w] <= wr_hprot[w];
            end
        end
    end

    // every line starts invalid, every pointer at way 0.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < L2_SETS; s++) begin
                evict_mem[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    state_mem[s][w] <= INVALID;
                end
            end
        end else if (wr_set) begin
            evict_mem[set_idx] <= wr_evict_way;
            for (int w = 0; w < WAYS; w++) begin
                state_mem[set_idx][w] <= wr_state[w];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registered whole-set read.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rd_set) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_data_line[w]  <= line_mem[set_idx][w];
                rd_data_tag[w]   <= tag_mem[set_idx][w];
                rd_data_hprot[w] <= hprot_mem[set_idx][w];
                rd_data_state[w] <= state_mem[set_idx][w];
            end
            rd_data_evict_way <= evict_mem[set_idx];
        end
    end

endmodule

`default_nettype wire

// ==== logic/l2_bufs.sv ====
`default_nettype none

module l2_bufs
    import l2_pkg::*;
#(
    parameter  int WAYS     = 4,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_mem_en,
    input  logic                incr_evict_way_buf,
    input  logic [WAY_BITS-1:0] way,
    input  logic                wr_en_lines_buf,
    input  logic                wr_en_tags_buf,
    input  logic                wr_en_states_buf,
    input  logic                wr_en_hprots_buf,
    input  line_t               lines_buf_wr_data,
    input  l2_tag_t             tags_buf_wr_data,
    input  state_t              states_buf_wr_data,
    input  hprot_t              hprots_buf_wr_data,
    input  line_t               rd_data_line [WAYS],
    input  l2_tag_t             rd_data_tag [WAYS],
    input  hprot_t              rd_data_hprot [WAYS],
    input  state_t              rd_data_state [WAYS],
    input  logic [WAY_BITS-1:0] rd_data_evict_way,
    output logic [WAY_BITS-1:0] evict_way_buf,
    output line_t               lines_buf [WAYS],
    output l2_tag_t             tags_buf [WAYS],
    output hprot_t              hprots_buf [WAYS],
    output state_t              states_buf [WAYS]
);

    // eviction pointer, wraps at WAYS.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            evict_way_buf <= '0;
        end else if (rd_mem_en) begin
            evict_way_buf <= rd_data_evict_way;
        end else if (incr_evict_way_buf) begin
            evict_way_buf <= evict_way_buf + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-way fields.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < WAYS; i++) begin
                lines_buf[i]  <= '0;
                tags_buf[i]   <= '0;
                hprots_buf[i] <= '0;
                states_buf[i] <= INVALID;
            end
        end else if (rd_mem_en) begin
            // a set load wins over field writes.
            for (int i = 0; i < WAYS; i++) begin
                lines_buf[i]  <= rd_data_line[i];
                tags_buf[i]   <= rd_data_tag[i];
                hprots_buf[i] <= rd_data_hprot[i];
                states_buf[i] <= rd_data_state[i];
            end
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (way == WAY_BITS'(i)) begin
                    if (wr_en_lines_buf) begin
                        lines_buf[i] <= lines_buf_wr_data;
                    end
                    if (wr_en_tags_buf) begin
                        tags_buf[i] <= tags_buf_wr_data;
                    end
                    if (wr_en_hprots_buf) begin
                        hprots_buf[i] <= hprots_buf_wr_data;
                    end
                    if (wr_en_states_buf) begin
                        states_buf[i] <= states_buf_wr_data;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/l2_way_select.sv ====
`default_nettype none

module l2_way_select
    import l2_pkg::*;
#(
    parameter  int WAYS     = 4,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  l2_tag_t             req_tag,
    input  l2_tag_t             tags_buf [WAYS],
    input  state_t              states_buf [WAYS],
    input  logic [WAY_BITS-1:0] evict_way_buf,
    output logic                hit,
    output logic [WAY_BITS-1:0] hit_way,
    output logic [WAY_BITS-1:0] victim_way
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tag match.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scanned from the top so the lowest match is kept.
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (states_buf[i] != INVALID && tags_buf[i] == req_tag) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(i);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // victim pick.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // a free way first, round robin only on a full set.
    always_comb begin
        victim_way = evict_way_buf;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (states_buf[i] == INVALID) begin
                victim_way = WAY_BITS'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/l2_ctrl.sv ====
`default_nettype none

module l2_ctrl
    import l2_pkg::*;
#(
    parameter  int WAYS     = 4,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  l2_req_t                req_data,
    output logic                   ack,
    output l2_rsp_t                rsp,
    output logic [L2_SET_BITS-1:0] set_idx,
    output logic                   rd_set,
    output logic                   wr_set,
    output logic                   rd_mem_en,
    output logic [WAY_BITS-1:0]    way,
    output logic                   wr_en_lines_buf,
    output logic                   wr_en_tags_buf,
    output logic                   wr_en_states_buf,
    output logic                   wr_en_hprots_buf,
    output line_t                  lines_buf_wr_data,
    output l2_tag_t                tags_buf_wr_data,
    output state_t                 states_buf_wr_data,
    output hprot_t                 hprots_buf_wr_data,
    output logic                   incr_evict_way_buf,
    input  logic                   hit,
    input  logic [WAY_BITS-1:0]    hit_way,
    input  logic [WAY_BITS-1:0]    victim_way,
    input  line_t                  lines_buf [WAYS],
    input  hprot_t                 hprots_buf [WAYS],
    input  state_t                 states_buf [WAYS],
    input  l2_tag_t                tags_buf [WAYS]
);

    typedef enum logic [2:0] {
        IDLE, READ, LOAD, DECIDE, UPDATE, WRBACK, RESP
    } fsm_t;

    fsm_t    fsm;
    l2_req_t req_q;
    logic    hit_q;
    state_t  way_state;
    l2_rsp_t rsp_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fsm   <= IDLE;
            ack   <= 1'b0;
            hit_q <= 1'b0;
            way   <= '0;
        end else begin
            case (fsm)
                IDLE: begin
                    if (req) begin
                        fsm <= READ;
                    end
                end
                READ:   fsm <= LOAD;
                LOAD:   fsm <= DECIDE;
                DECIDE: begin
                    hit_q <= hit;
                    way   <= hit ? hit_way : victim_way;
                    fsm   <= UPDATE;
                end
                UPDATE: fsm <= WRBACK;
                WRBACK: fsm <= RESP;
                RESP: begin
                    // ack holds until the requester lets go.
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack <= 1'b0;
                        fsm <= IDLE;
                    end
                end
                default: fsm <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fsm == IDLE && req) begin
            req_q <= req_data;
        end
        if (fsm == UPDATE) begin
            rsp <= rsp_next;
        end
    end

    assign set_idx   = set_of(req_q.addr);
    assign rd_set    = (fsm == READ);
    assign rd_mem_en = (fsm == LOAD);
    assign wr_set    = (fsm == WRBACK);

    assign lines_buf_wr_data  = req_q.wr_line;
    assign tags_buf_wr_data   = tag_of(req_q.addr);
    assign hprots_buf_wr_data = req_q.wr_hprot;
    assign states_buf_wr_data = (req_q.op == OP_INVAL) ? INVALID : DIRTY;

    assign way_state = states_buf[way];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // update and response.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writes return no line, only the new state.
    always_comb begin
        wr_en_lines_buf    = 1'b0;
        wr_en_tags_buf     = 1'b0;
        wr_en_states_buf   = 1'b0;
        wr_en_hprots_buf   = 1'b0;
        incr_evict_way_buf = 1'b0;
        rsp_next           = '0;
        if (fsm == UPDATE) begin
            case (req_q.op)
                OP_READ: begin
                    if (hit_q) begin
                        rsp_next.hit      = 1'b1;
                        rsp_next.rd_line  = lines_buf[way];
                        rsp_next.rd_hprot = hprots_buf[way];
                        rsp_next.state    = way_state;
                    end
                end
                OP_WRITE: begin
                    wr_en_lines_buf  = 1'b1;
                    wr_en_hprots_buf = 1'b1;
                    wr_en_states_buf = 1'b1;
                    rsp_next.hit     = hit_q;
                    rsp_next.state   = DIRTY;
                    if (!hit_q) begin
                        wr_en_tags_buf = 1'b1;
                        // a live victim means the set was full.
                        if (way_state != INVALID) begin
                            incr_evict_way_buf   = 1'b1;
                            rsp_next.evicted     = 1'b1;
                            rsp_next.evict_tag   = tags_buf[way];
                            rsp_next.evict_dirty = (way_state == DIRTY);
                        end
                    end
                end
                OP_INVAL: begin
                    if (hit_q) begin
                        wr_en_states_buf     = 1'b1;
                        rsp_next.hit         = 1'b1;
                        rsp_next.rd_line     = lines_buf[way];
                        rsp_next.rd_hprot    = hprots_buf[way];
                        rsp_next.state       = INVALID;
                        rsp_next.evict_dirty = (way_state == DIRTY);
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/l2_set_core.sv ====
`default_nettype none

module l2_set_core
    import l2_pkg::*;
#(
    parameter  int WAYS     = 4,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    req,
    input  l2_req_t req_data,
    output logic    ack,
    output l2_rsp_t rsp
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // array and buffer nets.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [L2_SET_BITS-1:0] set_idx;
    logic                   rd_set;
    logic                   wr_set;
    logic                   rd_mem_en;
    logic                   incr_evict_way_buf;
    logic [WAY_BITS-1:0]    way;
    logic                   wr_en_lines_buf;
    logic                   wr_en_tags_buf;
    logic                   wr_en_states_buf;
    logic                   wr_en_hprots_buf;
    line_t                  lines_buf_wr_data;
    l2_tag_t                tags_buf_wr_data;
    state_t                 states_buf_wr_data;
    hprot_t                 hprots_buf_wr_data;

    line_t                  rd_data_line [WAYS];
    l2_tag_t                rd_data_tag [WAYS];
    hprot_t                 rd_data_hprot [WAYS];
    state_t                 rd_data_state [WAYS];
    logic [WAY_BITS-1:0]    rd_data_evict_way;

    logic [WAY_BITS-1:0]    evict_way_buf;
    line_t                  lines_buf [WAYS];
    l2_tag_t                tags_buf [WAYS];
    hprot_t                 hprots_buf [WAYS];
    state_t                 states_buf [WAYS];

    logic                   hit;
    logic [WAY_BITS-1:0]    hit_way;
    logic [WAY_BITS-1:0]    victim_way;

    l2_ctrl #(.WAYS(WAYS)) u_l2_ctrl (
        .clk, .rst, .req, .req_data, .ack, .rsp,
        .set_idx, .rd_set, .wr_set, .rd_mem_en, .way,
        .wr_en_lines_buf, .wr_en_tags_buf, .wr_en_states_buf, .wr_en_hprots_buf,
        .lines_buf_wr_data, .tags_buf_wr_data, .states_buf_wr_data, .hprots_buf_wr_data,
        .incr_evict_way_buf, .hit, .hit_way, .victim_way,
        .lines_buf, .hprots_buf, .states_buf, .tags_buf
    );

    // write-back takes the buffer outputs as they stand.
    l2_set_array #(.WAYS(WAYS)) u_l2_set_array (
        .clk, .rst, .set_idx, .rd_set, .wr_set,
        .wr_line(lines_buf), .wr_tag(tags_buf), .wr_hprot(hprots_buf),
        .wr_state(states_buf), .wr_evict_way(evict_way_buf),
        .rd_data_line, .rd_data_tag, .rd_data_hprot, .rd_data_state, .rd_data_evict_way
    );

    l2_bufs #(.WAYS(WAYS)) u_l2_bufs (
        .clk, .rst, .rd_mem_en, .incr_evict_way_buf, .way,
        .wr_en_lines_buf, .wr_en_tags_buf, .wr_en_states_buf, .wr_en_hprots_buf,
        .lines_buf_wr_data, .tags_buf_wr_data, .states_buf_wr_data, .hprots_buf_wr_data,
        .rd_data_line, .rd_data_tag, .rd_data_hprot, .rd_data_state, .rd_data_evict_way,
        .evict_way_buf, .lines_buf, .tags_buf, .hprots_buf, .states_buf
    );

    // the request tag is the tag write data.
    l2_way_select #(.WAYS(WAYS)) u_l2_way_select (
        .req_tag(tags_buf_wr_data), .tags_buf, .states_buf, .evict_way_buf,
        .hit, .hit_way, .victim_way
    );

endmodule

`default_nettype wire

// ==== testbench/tb_l2_set_core.sv ====
`default_nettype none

module tb_l2_set_core
    import l2_pkg::*;
();

    localparam int WAYS         = 4;
    localparam int DRIVE_DELAY  = 10;
    localparam int WAIT_LIMIT   = 20;
    localparam int ACK_LATENCY  = 6;
    localparam int RANDOM_COUNT = 48;

    // one table row and the outcome the directed rows aim for.
    typedef struct packed {
        l2_op_t     op;
        addr_t      addr;
        line_t      data;
        hprot_t     hprot;
        logic [3:0] hold;
        logic       known;
        logic       exp_hit;
        logic       exp_evicted;
    } stim_t;

    logic    clk = 1'b0;
    logic    rst;
    logic    req;
    l2_req_t req_data;
    logic    ack;
    l2_rsp_t rsp;

    stim_t   stim_q [$];
    int      entry_idx;
    int      seed = 32'ha552;

    // reference state of the cache.
    l2_tag_t m_tag   [L2_SETS][WAYS];
    line_t   m_line  [L2_SETS][WAYS];
    hprot_t  m_hprot [L2_SETS][WAYS];
    state_t  m_state [L2_SETS][WAYS];
    int      m_ptr   [L2_SETS];

    l2_set_core #(.WAYS(WAYS)) u_l2_set_core (
        .clk, .rst, .req, .req_data, .ack, .rsp
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // failure reporting.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_on_error();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%0h expected 0x%0h (entry %0d)",
                     name, got, exp, entry_idx);
            stop_on_error();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic model_step(input stim_t e, output l2_rsp_t r);
        logic [L2_SET_BITS-1:0] s;
        l2_tag_t                t;
        int                     hw;
        int                     v;
        s  = e.addr[L2_SET_BITS-1:0];
        t  = e.addr[ADDR_BITS-1:L2_SET_BITS];
        hw = -1;
        v  = -1;
        r  = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hw < 0 && m_state[s][w] != INVALID && m_tag[s][w] == t) begin
                hw = w;
            end
            if (v < 0 && m_state[s][w] == INVALID) begin
                v = w;
            end
        end
        // full set falls back on round robin.
        if (v < 0) begin
            v = m_ptr[s];
        end
        case (e.op)
            OP_READ: begin
                if (hw >= 0) begin
                    r.hit      = 1'b1;
                    r.rd_line  = m_line[s][hw];
                    r.rd_hprot = m_hprot[s][hw];
                    r.state    = m_state[s][hw];
                end
            end
            OP_WRITE: begin
                r.hit   = (hw >= 0);
                r.state = DIRTY;
                if (hw < 0) begin
                    if (m_state[s][v] != INVALID) begin
                        r.evicted     = 1'b1;
                        r.evict_tag   = m_tag[s][v];
                        r.evict_dirty = (m_state[s][v] == DIRTY);
                        m_ptr[s]      = (m_ptr[s] + 1) % WAYS;
                    end
                    hw           = v;
                    m_tag[s][hw] = t;
                end
                m_line[s][hw]  = e.data;
                m_hprot[s][hw] = e.hprot;
                m_state[s][hw] = DIRTY;
            end
            OP_INVAL: begin
                if (hw >= 0) begin
                    r.hit          = 1'b1;
                    r.rd_line      = m_line[s][hw];
                    r.rd_hprot     = m_hprot[s][hw];
                    r.state        = INVALID;
                    r.evict_dirty  = (m_state[s][hw] == DIRTY);
                    m_state[s][hw] = INVALID;
                end
            end
            default: ;
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake driver.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_request(input stim_t e, output l2_rsp_t got);
        int cycles;
        req_data.op       = e.op;
        req_data.addr     = e.addr;
        req_data.wr_line  = e.data;
        req_data.wr_hprot = e.hprot;
        req               = 1'b1;
        cycles            = 0;
        while (!ack && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (!ack) begin
            $display("timed out waiting for ack to rise on entry %0d", entry_idx);
            stop_on_error();
        end
        // the accepting edge is not part of the latency.
        check_value("ack latency", 64'(cycles - 1), 64'(ACK_LATENCY));
        got = rsp;
        // requester back-pressure.
        repeat (e.hold) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_value("ack", 64'(ack), 64'd1);
            check_value("rsp", 64'(rsp), 64'(got));
        end
        req    = 1'b0;
        cycles = 0;
        while (ack && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (ack) begin
            $display("ack did not fall after req was released on entry %0d", entry_idx);
            stop_on_error();
        end
    endtask

    task automatic push_entry(input l2_op_t op, input addr_t addr, input line_t data,
                              input hprot_t hprot, input int hold, input logic known,
                              input logic exp_hit, input logic exp_evicted);
        stim_t e;
        e.op          = op;
        e.addr        = addr;
        e.data        = data;
        e.hprot       = hprot;
        e.hold        = 4'(hold);
        e.known       = known;
        e.exp_hit     = exp_hit;
        e.exp_evicted = exp_evicted;
        stim_q.push_back(e);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        logic [31:0] rnd;
        l2_op_t      op;
        addr_t       addr;
        push_entry(OP_READ,  16'h1230, 32'h0,         2'd0, 0, 1'b1, 1'b0, 1'b0);
        // new line, a hit on it, a rewrite.
        push_entry(OP_WRITE, 16'h0015, 32'ha5a5_0001, 2'd2, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_READ,  16'h0015, 32'h0,         2'd0, 5, 1'b1, 1'b1, 1'b0);
        push_entry(OP_WRITE, 16'h0015, 32'h5a5a_0002, 2'd1, 2, 1'b1, 1'b1, 1'b0);
        push_entry(OP_READ,  16'h0015, 32'h0,         2'd0, 0, 1'b1, 1'b1, 1'b0);
        // set 7 fills and then evicts in turn.
        push_entry(OP_WRITE, 16'h0017, 32'h7000_0001, 2'd1, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0027, 32'h7000_0002, 2'd2, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0037, 32'h7000_0003, 2'd3, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0047, 32'h7000_0004, 2'd0, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0057, 32'h7000_0005, 2'd1, 3, 1'b1, 1'b0, 1'b1);
        push_entry(OP_READ,  16'h0017, 32'h0,         2'd0, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0067, 32'h7000_0006, 2'd2, 0, 1'b1, 1'b0, 1'b1);
        push_entry(OP_READ,  16'h0037, 32'h0,         2'd0, 0, 1'b1, 1'b1, 1'b0);
        // set 9 loses a way to an invalidate.
        push_entry(OP_WRITE, 16'h0019, 32'h9000_0001, 2'd1, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0029, 32'h9000_0002, 2'd2, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0039, 32'h9000_0003, 2'd3, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0049, 32'h9000_0004, 2'd0, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_INVAL, 16'h0029, 32'h0,         2'd0, 4, 1'b1, 1'b1, 1'b0);
        push_entry(OP_READ,  16'h0029, 32'h0,         2'd0, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_INVAL, 16'h0ab9, 32'h0,         2'd0, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0059, 32'h9000_0005, 2'd1, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_WRITE, 16'h0069, 32'h9000_0006, 2'd2, 0, 1'b1, 1'b0, 1'b1);
        push_entry(OP_READ,  16'h0019, 32'h0,         2'd0, 0, 1'b1, 1'b0, 1'b0);
        push_entry(OP_READ,  16'h0049, 32'h0,         2'd0, 0, 1'b1, 1'b1, 1'b0);
        // random tail over six tags in three sets, half of it writes.
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            rnd  = $random(seed);
            op   = (rnd[17:16] == 2'd3) ? OP_WRITE : l2_op_t'(rnd[17:16]);
            addr = {4'h0, 8'(rnd[7:0] % 8'd6), 4'(rnd[15:8] % 8'd3)};
            push_entry(op, addr, $random(seed), rnd[19:18], int'(rnd[21:20]),
                       1'b0, 1'b0, 1'b0);
        end
    endtask

    initial begin
        l2_rsp_t got;
        l2_rsp_t exp;
        rst       = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        entry_idx = -1;
        for (int s = 0; s < L2_SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_line[s][w]  = '0;
                m_hprot[s][w] = '0;
                m_state[s][w] = INVALID;
            end
        end
        build_table();
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("ack", 64'(ack), 64'd0);
        foreach (stim_q[i]) begin
            entry_idx = i;
            model_step(stim_q[i], exp);
            run_request(stim_q[i], got);
            if (stim_q[i].known) begin
                check_value("rsp.hit (table)", 64'(got.hit), 64'(stim_q[i].exp_hit));
                check_value("rsp.evicted (table)", 64'(got.evicted),
                            64'(stim_q[i].exp_evicted));
            end
            check_value("rsp.hit", 64'(got.hit), 64'(exp.hit));
            check_value("rsp.rd_line", 64'(got.rd_line), 64'(exp.rd_line));
            check_value("rsp.rd_hprot", 64'(got.rd_hprot), 64'(exp.rd_hprot));
            check_value("rsp.state", 64'(got.state), 64'(exp.state));
            check_value("rsp.evicted", 64'(got.evicted), 64'(exp.evicted));
            check_value("rsp.evict_tag", 64'(got.evict_tag), 64'(exp.evict_tag));
            check_value("rsp.evict_dirty", 64'(got.evict_dirty), 64'(exp.evict_dirty));
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== l2_set_core.f ====
logic/l2_pkg.sv
logic/l2_set_array.sv
logic/l2_bufs.sv
logic/l2_way_select.sv
logic/l2_ctrl.sv
logic/l2_set_core.sv
testbench/tb_l2_set_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_l2_set_core
FILELIST  ?= l2_set_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
